//--- hw/stm_pkg.sv
`default_nettype none

package stm_pkg;

  // The system time counts fine ticks and the timer works on coarser units
  localparam int SYS_TIME_W = 64;
  localparam int TIME_SHIFT = 8;
  localparam int DIVIDEND_W = SYS_TIME_W - TIME_SHIFT;

  localparam int FREQ_DIV_W = 16;
  localparam int CYCLE_W = 13;
  localparam int IDX_W = 13;

  localparam int NUM_SEGMENT_DEFAULT = 2;
  localparam int SEG_W = 1;

  // Input register, one stage per quotient bit, output register
  function automatic int div_latency(input int dividend_w);
    return dividend_w + 2;
  endfunction

endpackage

`default_nettype wire

//--- hw/sys_time_counter.sv
`timescale 1ns/100ps
`default_nettype none

module sys_time_counter #(
  parameter logic [stm_pkg::SYS_TIME_W-1:0] TIME_STEP = 1
) (
  input  logic                            CLK,
  input  logic                            arst_n,
  input  logic                            time_load,
  input  logic [stm_pkg::SYS_TIME_W-1:0]  time_value,
  output logic [stm_pkg::SYS_TIME_W-1:0]  sys_time
);

  logic [stm_pkg::SYS_TIME_W-1:0] next_time;

  // Wraps around silently at the top of the 64-bit range
  assign next_time = sys_time + TIME_STEP;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sys_time <= '0;
    end else if (time_load) begin
      // A load takes priority over the step in the same cycle
      sys_time <= time_value;
    end else begin
      sys_time <= next_time;
    end
  end

endmodule

`default_nettype wire

//--- hw/pipe_divider.sv
`timescale 1ns/100ps
`default_nettype none

module pipe_divider #(
  parameter int DIVIDEND_W = 56,
  parameter int DIVISOR_W = 16
) (
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic [DIVIDEND_W-1:0] dividend,
  input  logic [DIVISOR_W-1:0]  divisor,
  output logic [DIVIDEND_W-1:0] quotient,
  output logic [DIVISOR_W-1:0]  remainder
);

  // Stage 0 is the input register and stage i holds the state after i quotient bits.
  // The work word starts as the dividend and fills with quotient bits from the right
  logic [DIVIDEND_W-1:0] work_q [DIVIDEND_W+1];
  logic [DIVISOR_W-1:0]  rem_q  [1:DIVIDEND_W];
  logic [DIVISOR_W-1:0]  dsr_q  [DIVIDEND_W];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      work_q[0] <= '0;
      dsr_q[0]  <= DIVISOR_W'(1);
    end else begin
      work_q[0] <= dividend;
      dsr_q[0]  <= divisor;
    end
  end

  for (genvar i = 1; i <= DIVIDEND_W; i++) begin : g_stage
    logic [DIVISOR_W:0] trial;
    logic [DIVISOR_W:0] diff;
    logic               fits;

    // Bring down the next dividend bit and try the subtraction
    if (i == 1) begin : g_first
      // The partial remainder starts at zero
      assign trial = {{DIVISOR_W{1'b0}}, work_q[0][DIVIDEND_W-1]};
    end else begin : g_next
      assign trial = {rem_q[i-1], work_q[i-1][DIVIDEND_W-1]};
    end
    assign diff  = trial - {1'b0, dsr_q[i-1]};
    // With a zero divisor every bit fits, so the quotient is all ones and
    // the remainder ends up as the low dividend bits
    assign fits  = trial >= {1'b0, dsr_q[i-1]};

    always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
        work_q[i] <= '0;
        rem_q[i]  <= '0;
      end else begin
        work_q[i] <= {work_q[i-1][DIVIDEND_W-2:0], fits};
        rem_q[i]  <= fits ? diff[DIVISOR_W-1:0] : trial[DIVISOR_W-1:0];
      end
    end

    // The divisor rides along until the last bit stage has used it
    if (i < DIVIDEND_W) begin : g_dsr
      always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
          dsr_q[i] <= DIVISOR_W'(1);
        end else begin
          dsr_q[i] <= dsr_q[i-1];
        end
      end
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      quotient  <= '0;
      remainder <= '0;
    end else begin
      quotient  <= work_q[DIVIDEND_W];
      remainder <= rem_q[DIVIDEND_W];
    end
  end

endmodule

`default_nettype wire

//--- hw/stm_timer.sv
`timescale 1ns/100ps
`default_nettype none

module stm_timer #(
  parameter int NUM_SEGMENT = stm_pkg::NUM_SEGMENT_DEFAULT
) (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  logic                           update_settings,
  input  logic [stm_pkg::SYS_TIME_W-1:0] sys_time,
  input  logic [stm_pkg::CYCLE_W-1:0]    cycle [NUM_SEGMENT],
  input  logic [stm_pkg::FREQ_DIV_W-1:0] freq_div [NUM_SEGMENT],
  output logic [stm_pkg::IDX_W-1:0]      idx [NUM_SEGMENT],
  output logic                           update_done
);

  import stm_pkg::*;

  // Two dividers back to back, so new settings take this long to reach idx
  localparam int LOAD_CYCLES = 2 * div_latency(DIVIDEND_W);
  localparam int CNT_W = $clog2(LOAD_CYCLES);
  localparam int CYCLE_LEN_W = CYCLE_W + 1;

  typedef enum logic {
    IDLE,
    LOAD
  } state_t;

  state_t                 state;
  logic [CNT_W-1:0]       cnt;
  logic                   accept;
  logic [FREQ_DIV_W-1:0]  freq_div_q [NUM_SEGMENT];
  logic [CYCLE_LEN_W-1:0] cycle_len_q [NUM_SEGMENT];

  assign accept = (state == IDLE) && update_settings;

  // Cycle holds the last index, the divider needs the length
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < NUM_SEGMENT; s++) begin
        freq_div_q[s]  <= FREQ_DIV_W'(1);
        cycle_len_q[s] <= CYCLE_LEN_W'(1);
      end
    end else if (accept) begin
      for (int s = 0; s < NUM_SEGMENT; s++) begin
        freq_div_q[s]  <= freq_div[s];
        cycle_len_q[s] <= CYCLE_LEN_W'(cycle[s]) + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state       <= IDLE;
      cnt         <= '0;
      update_done <= 1'b0;
    end else begin
      update_done <= 1'b0;
      case (state)
        IDLE: begin
          cnt <= '0;
          if (update_settings) begin
            state <= LOAD;
          end
        end
        LOAD: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(LOAD_CYCLES - 1)) begin
            update_done <= 1'b1;
            state       <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  for (genvar i = 0; i < NUM_SEGMENT; i++) begin : g_seg
    logic [DIVIDEND_W-1:0] quo;
    logic [FREQ_DIV_W-1:0] idx_rem;

    // Coarse time divided by the sampling divider gives the sample count
    pipe_divider #(
      .DIVIDEND_W (DIVIDEND_W),
      .DIVISOR_W  (FREQ_DIV_W)
    ) u_div_time (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .dividend  (sys_time[SYS_TIME_W-1:TIME_SHIFT]),
      .divisor   (freq_div_q[i]),
      .quotient  (quo),
      .remainder ()
    );

    // Sample count modulo the cycle length gives the index
    pipe_divider #(
      .DIVIDEND_W (DIVIDEND_W),
      .DIVISOR_W  (FREQ_DIV_W)
    ) u_div_idx (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .dividend  (quo),
      .divisor   ({{(FREQ_DIV_W - CYCLE_LEN_W){1'b0}}, cycle_len_q[i]}),
      .quotient  (),
      .remainder (idx_rem)
    );

    assign idx[i] = idx_rem[IDX_W-1:0];

    // An accepted divider setting must be usable by the time pipeline
    a_freq_div_nonzero: assert property (
      @(posedge CLK) disable iff (!arst_n)
      accept |=> (freq_div_q[i] != '0)
    ) else $error("segment %0d latched a zero frequency divider", i);
  end

  a_done_single: assert property (
    @(posedge CLK) disable iff (!arst_n)
    update_done |=> !update_done
  ) else $error("update_done held longer than one cycle");

endmodule

`default_nettype wire

//--- hw/segment_select.sv
`timescale 1ns/100ps
`default_nettype none

module segment_select #(
  parameter int NUM_SEGMENT = stm_pkg::NUM_SEGMENT_DEFAULT
) (
  input  logic                      CLK,
  input  logic                      arst_n,
  input  logic                      segment_req,
  input  logic [stm_pkg::SEG_W-1:0] segment_id,
  input  logic [stm_pkg::IDX_W-1:0] idx [NUM_SEGMENT],
  output logic [stm_pkg::SEG_W-1:0] active_segment,
  output logic [stm_pkg::IDX_W-1:0] active_idx
);

  import stm_pkg::*;

  logic             pending;
  logic [SEG_W-1:0] pending_id;
  logic [IDX_W-1:0] prev_idx;
  logic             wrap;
  logic             switch_now;

  assign active_idx = idx[active_segment];

  // A wrap is the first zero after a nonzero index of the active segment
  assign wrap       = (active_idx == '0) && (prev_idx != '0);
  assign switch_now = pending && wrap;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pending        <= 1'b0;
      active_segment <= '0;
      prev_idx       <= '0;
    end else begin
      // A new request in the switch cycle stays pending for the next wrap
      if (segment_req) begin
        pending <= 1'b1;
      end else if (switch_now) begin
        pending <= 1'b0;
      end

      if (switch_now) begin
        active_segment <= pending_id;
        prev_idx       <= idx[pending_id];
      end else begin
        prev_idx <= active_idx;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (segment_req) begin
      pending_id <= segment_id;
    end
  end

  a_switch_on_wrap: assert property (
    @(posedge CLK) disable iff (!arst_n)
    $changed(active_segment) |-> $past(switch_now)
  ) else $error("active segment changed without a pending switch at a wrap");

endmodule

`default_nettype wire

//--- hw/stm_timing_top.sv
`timescale 1ns/100ps
`default_nettype none

module stm_timing_top #(
  parameter int                             NUM_SEGMENT = stm_pkg::NUM_SEGMENT_DEFAULT,
  parameter logic [stm_pkg::SYS_TIME_W-1:0] TIME_STEP = 1
) (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  logic                           time_load,
  input  logic [stm_pkg::SYS_TIME_W-1:0] time_value,
  input  logic                           update_settings,
  input  logic [stm_pkg::CYCLE_W-1:0]    cycle [NUM_SEGMENT],
  input  logic [stm_pkg::FREQ_DIV_W-1:0] freq_div [NUM_SEGMENT],
  input  logic                           segment_req,
  input  logic [stm_pkg::SEG_W-1:0]      segment_id,
  output logic [stm_pkg::SYS_TIME_W-1:0] sys_time,
  output logic [stm_pkg::IDX_W-1:0]      idx [NUM_SEGMENT],
  output logic                           update_done,
  output logic [stm_pkg::SEG_W-1:0]      active_segment,
  output logic [stm_pkg::IDX_W-1:0]      active_idx
);

  sys_time_counter #(
    .TIME_STEP (TIME_STEP)
  ) u_time (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .time_load  (time_load),
    .time_value (time_value),
    .sys_time   (sys_time)
  );

  stm_timer #(
    .NUM_SEGMENT (NUM_SEGMENT)
  ) u_timer (
    .CLK             (CLK),
    .arst_n          (arst_n),
    .update_settings (update_settings),
    .sys_time        (sys_time),
    .cycle           (cycle),
    .freq_div        (freq_div),
    .idx             (idx),
    .update_done     (update_done)
  );

  segment_select #(
    .NUM_SEGMENT (NUM_SEGMENT)
  ) u_select (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .segment_req    (segment_req),
    .segment_id     (segment_id),
    .idx            (idx),
    .active_segment (active_segment),
    .active_idx     (active_idx)
  );

endmodule

`default_nettype wire

//--- bench/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
  output logic CLK,
  output logic arst_n
);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Reset is released on a falling edge after ten rising edges
  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/stm_timing_tb.sv
`timescale 1ns/100ps
`default_nettype none

module stm_timing_tb;

  import stm_pkg::*;

  localparam int NSEG = 2;
  localparam int NUM_TESTS = 6;
  localparam int HALF_DELAY = 58;
  localparam int FULL_DELAY = 116;
  localparam int HIST = 256;
  localparam int DONE_WAIT_MAX = 200;

  logic                  CLK;
  logic                  arst_n;
  logic                  time_load;
  logic [SYS_TIME_W-1:0] time_value;
  logic                  update_settings;
  logic [CYCLE_W-1:0]    cycle_in [NSEG];
  logic [FREQ_DIV_W-1:0] fd_in [NSEG];
  logic                  segment_req;
  logic [SEG_W-1:0]      segment_id;
  logic [SYS_TIME_W-1:0] sys_time;
  logic [IDX_W-1:0]      idx [NSEG];
  logic                  update_done;
  logic [SEG_W-1:0]      active_segment;
  logic [IDX_W-1:0]      active_idx;

  // Stimulus table, one row per test
  string                 row_name [NUM_TESTS];
  logic [SYS_TIME_W-1:0] row_time [NUM_TESTS];
  logic [CYCLE_W-1:0]    row_cycle [NUM_TESTS][NSEG];
  logic [FREQ_DIV_W-1:0] row_fd [NUM_TESTS][NSEG];
  logic                  row_req [NUM_TESTS];
  logic [SEG_W-1:0]      row_seg [NUM_TESTS];
  logic                  row_twice [NUM_TESTS];
  int                    row_obs [NUM_TESTS];

  // Reference model state
  logic [SYS_TIME_W-1:0] exp_time;
  logic [SYS_TIME_W-1:0] time_hist [HIST];
  logic [FREQ_DIV_W-1:0] fd_hist [NSEG][HIST];
  logic [CYCLE_W:0]      len_hist [NSEG][HIST];
  logic [FREQ_DIV_W-1:0] fd_cur [NSEG];
  logic [CYCLE_W:0]      len_cur [NSEG];
  logic [IDX_W-1:0]      eidx [NSEG];
  logic [SEG_W-1:0]      m_active;
  logic [SEG_W-1:0]      m_pid;
  logic                  m_pending;
  logic [IDX_W-1:0]      m_prev;
  int                    busy_until;
  int                    done_cycle;

  int    cyc;
  int    limit;
  int    edge_count;
  int    errors;
  int    test_errs;
  int    passed;
  int    failed;
  string cur_name;

  clk_gen u_clk (
    .CLK    (CLK),
    .arst_n (arst_n)
  );

  stm_timing_top #(
    .NUM_SEGMENT (NSEG),
    .TIME_STEP   (64'd1)
  ) DUT (
    .CLK             (CLK),
    .arst_n          (arst_n),
    .time_load       (time_load),
    .time_value      (time_value),
    .update_settings (update_settings),
    .cycle           (cycle_in),
    .freq_div        (fd_in),
    .segment_req     (segment_req),
    .segment_id      (segment_id),
    .sys_time        (sys_time),
    .idx             (idx),
    .update_done     (update_done),
    .active_segment  (active_segment),
    .active_idx      (active_idx)
  );

  function automatic logic [IDX_W-1:0] model_index(input logic [SYS_TIME_W-1:0] t,
                                                   input logic [FREQ_DIV_W-1:0] fd,
                                                   input logic [CYCLE_W:0] len);
    logic [SYS_TIME_W-1:0] samples;
    samples = (t >> 8) / 64'(fd);
    return IDX_W'(samples % 64'(len));
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("FAIL %s: %s expected %0h actual %0h at cycle %0d", cur_name, what, exp, act, cyc);
      errors++;
      test_errs++;
    end
  endtask

  // Advance one cycle, update the model from last cycle's inputs and check the outputs
  task automatic step_cycle();
    logic [IDX_W-1:0] a_idx;
    logic             sw;
    logic [SEG_W-1:0] sw_id;
    int               old_pos;
    int               mid_pos;
    @(negedge CLK);
    cyc++;
    a_idx = eidx[m_active];
    sw    = m_pending && (a_idx == '0) && (m_prev != '0);
    sw_id = m_pid;
    if (segment_req) begin
      m_pending = 1'b1;
      m_pid     = segment_id;
    end else if (sw) begin
      m_pending = 1'b0;
    end
    if (sw) begin
      m_active = sw_id;
      m_prev   = eidx[sw_id];
    end else begin
      m_prev = a_idx;
    end
    exp_time = time_load ? time_value : exp_time + 64'd1;
    if (update_settings && (cyc - 1 > busy_until)) begin
      for (int s = 0; s < NSEG; s++) begin
        fd_cur[s]  = fd_in[s];
        len_cur[s] = {1'b0, cycle_in[s]} + 14'd1;
      end
      busy_until = cyc + FULL_DELAY - 1;
      done_cycle = cyc + FULL_DELAY;
    end
    time_hist[cyc % HIST] = exp_time;
    old_pos = (cyc + HIST - FULL_DELAY) % HIST;
    mid_pos = (cyc + HIST - HALF_DELAY) % HIST;
    for (int s = 0; s < NSEG; s++) begin
      fd_hist[s][cyc % HIST]  = fd_cur[s];
      len_hist[s][cyc % HIST] = len_cur[s];
      eidx[s] = model_index(time_hist[old_pos], fd_hist[s][old_pos], len_hist[s][mid_pos]);
      check_value($sformatf("idx[%0d]", s), 64'(eidx[s]), 64'(idx[s]));
    end
    check_value("sys_time", exp_time, sys_time);
    check_value("update_done", 64'(cyc == done_cycle), 64'(update_done));
    check_value("active_segment", 64'(m_active), 64'(active_segment));
    check_value("active_idx", 64'(eidx[m_active]), 64'(active_idx));
    time_load       = 1'b0;
    update_settings = 1'b0;
    segment_req     = 1'b0;
  endtask

  task automatic report_test();
    if (test_errs == 0) begin
      $display("PASS %s", cur_name);
      passed++;
    end else begin
      $display("FAIL %s: %0d mismatches", cur_name, test_errs);
      failed++;
    end
  endtask

  task automatic set_row(input int r, input string name, input logic [63:0] t,
                         input logic [12:0] c0, input logic [12:0] c1,
                         input logic [15:0] f0, input logic [15:0] f1,
                         input logic req, input logic seg, input logic twice, input int obs);
    row_name[r]     = name;
    row_time[r]     = t;
    row_cycle[r][0] = c0;
    row_cycle[r][1] = c1;
    row_fd[r][0]    = f0;
    row_fd[r][1]    = f1;
    row_req[r]      = req;
    row_seg[r]      = seg;
    row_twice[r]    = twice;
    row_obs[r]      = obs;
  endtask

  task automatic build_table();
    set_row(0, "update_and_resend", 64'h0000_0000_0001_0000, 13'd3, 13'd9, 16'd1, 16'd2,
            1'b0, 1'b0, 1'b1, 600);
    set_row(1, "time_wrap_switch", 64'hFFFF_FFFF_FFFF_FF00, 13'd1, 13'd4, 16'd1, 16'd1,
            1'b1, 1'b1, 1'b0, 900);
    set_row(2, "switch_back", 64'h0000_1234_5678_9A00, 13'd6, 13'd2, 16'd2, 16'd1,
            1'b1, 1'b0, 1'b0, 1000);
    set_row(3, "random_small", {$urandom, $urandom}, 13'($urandom % 8), 13'($urandom % 8),
            16'(1 + $urandom % 4), 16'(1 + $urandom % 4), 1'b0, 1'b0, 1'b0, 500);
    set_row(4, "near_wrap_random", ~64'($urandom % 2048), 13'($urandom % 6),
            13'($urandom % 6), 16'(1 + $urandom % 2), 16'(1 + $urandom % 2),
            1'b0, 1'b0, 1'b0, 600);
    set_row(5, "wide_random", {$urandom, $urandom}, 13'($urandom), 13'($urandom),
            16'($urandom % 65535 + 1), 16'($urandom % 65535 + 1), 1'b0, 1'b0, 1'b0, 400);
  endtask

  task automatic run_test(input int r);
    int sent_at;
    int waited;
    cur_name   = row_name[r];
    test_errs  = 0;
    time_load  = 1'b1;
    time_value = row_time[r];
    step_cycle();
    update_settings = 1'b1;
    for (int s = 0; s < NSEG; s++) begin
      cycle_in[s] = row_cycle[r][s];
      fd_in[s]    = row_fd[r][s];
    end
    sent_at = cyc;
    step_cycle();
    waited = 1;
    while (!update_done && waited < DONE_WAIT_MAX) begin
      // A second update in LOAD must be dropped
      if (row_twice[r] && waited == 40) begin
        update_settings = 1'b1;
        for (int s = 0; s < NSEG; s++) begin
          cycle_in[s] = 13'd11;
          fd_in[s]    = 16'd5;
        end
      end
      step_cycle();
      waited++;
    end
    if (!update_done) begin
      $display("FAIL %s: update_done did not arrive within %0d cycles", cur_name, DONE_WAIT_MAX);
      errors++;
      test_errs++;
    end else begin
      check_value("update_done delay", 64'(FULL_DELAY), 64'(cyc - sent_at - 1));
    end
    if (row_req[r]) begin
      segment_req = 1'b1;
      segment_id  = row_seg[r];
    end
    for (int k = 0; k < row_obs[r]; k++) begin
      step_cycle();
    end
    if (row_req[r] && m_active != row_seg[r]) begin
      $display("FAIL %s: no switch to segment %0d happened in the observation window",
               cur_name, row_seg[r]);
      errors++;
      test_errs++;
    end
    report_test();
  endtask

  always @(posedge CLK) begin
    edge_count++;
    if (edge_count > limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    time_load       = 1'b0;
    time_value      = '0;
    update_settings = 1'b0;
    segment_req     = 1'b0;
    segment_id      = '0;
    for (int s = 0; s < NSEG; s++) begin
      cycle_in[s] = '0;
      fd_in[s]    = 16'd1;
      fd_cur[s]   = 16'd1;
      len_cur[s]  = 14'd1;
      eidx[s]     = '0;
      for (int h = 0; h < HIST; h++) begin
        fd_hist[s][h]  = 16'd1;
        len_hist[s][h] = 14'd1;
      end
    end
    for (int h = 0; h < HIST; h++) begin
      time_hist[h] = '0;
    end
    exp_time   = '0;
    m_active   = '0;
    m_pid      = '0;
    m_pending  = 1'b0;
    m_prev     = '0;
    busy_until = -1;
    done_cycle = -1;
    cyc        = 0;
    edge_count = 0;
    errors     = 0;
    passed     = 0;
    failed     = 0;
    void'($urandom(32'h69de_e205));
    build_table();
    limit = 120;
    for (int r = 0; r < NUM_TESTS; r++) begin
      limit += row_obs[r] + FULL_DELAY + 10;
    end
    wait (arst_n === 1'b1);
    cur_name  = "reset_values";
    test_errs = 0;
    check_value("sys_time", 64'd0, sys_time);
    check_value("update_done", 64'd0, 64'(update_done));
    check_value("idx[0]", 64'd0, 64'(idx[0]));
    check_value("idx[1]", 64'd0, 64'(idx[1]));
    check_value("active_segment", 64'd0, 64'(active_segment));
    report_test();
    for (int r = 0; r < NUM_TESTS; r++) begin
      run_test(r);
    end
    $display("Tests passed %0d, failed %0d, check errors %0d", passed, failed, errors);
    if (errors == 0 && failed == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- stm_timing.f
hw/stm_pkg.sv
hw/sys_time_counter.sv
hw/pipe_divider.sv
hw/stm_timer.sv
hw/segment_select.sv
hw/stm_timing_top.sv
bench/clk_gen.sv
bench/stm_timing_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
	  --top-module stm_timing_tb -Mdir obj_dir -f stm_timing.f
	./obj_dir/Vstm_timing_tb | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
